// File: mem_test_params.svh
/* sizing for the memory test subsystem
   MT_ADDR_W must equal the sum of the five field widths and
   MT_RAM_DEPTH must equal 2**(MT_ROW_W + MT_COL_W) */
`ifndef MEM_TEST_PARAMS_SVH
`define MEM_TEST_PARAMS_SVH

// ---------------------------------------------------------------------------
// data path
// ---------------------------------------------------------------------------
// one test word
`define MT_LANE_W 16
// words per bus beat
`define MT_LANES 4
`define MT_BUS_W 64
// beats per burst, one row holds one burst
`define MT_BURST_LEN 4

// ---------------------------------------------------------------------------
// address fields, msb to lsb
// ---------------------------------------------------------------------------
`define MT_CS_W 1
`define MT_ROW_W 6
`define MT_BANK_W 2
// col is the beat index inside a burst
`define MT_COL_W 2
// byte offset inside a beat
`define MT_DP_W 3
`define MT_ADDR_W 14

// stored beats, row and col bits together
`define MT_RAM_DEPTH 256

`endif

// File: mem_test_pkg.sv
/* shared types for the memory test subsystem
   field order of the address union follows the controller map:
   cs, row, bank, col, byte offset */
`include "mem_test_params.svh"

package mem_test_pkg;

	// -----------------------------------------------------------------------
	// bus address
	// -----------------------------------------------------------------------
	// flat view travels on the AW and AR channels
	// field view is used to step rows and to index the RAM
	typedef union packed
	{
		logic [`MT_ADDR_W-1:0] word;
		struct packed
		{
			// chip select, tied low here
			logic [`MT_CS_W-1:0] cs;
			logic [`MT_ROW_W-1:0] row;
			// bank is never stepped
			logic [`MT_BANK_W-1:0] bank;
			// beat inside the burst
			logic [`MT_COL_W-1:0] col;
			// byte offset, always zero for full beats
			logic [`MT_DP_W-1:0] dp;
		} f;
	} mt_addr_u;

	// -----------------------------------------------------------------------
	// pattern data
	// -----------------------------------------------------------------------
	// one lane of the test pattern
	// lane value = seed + word index, wraps modulo 2**MT_LANE_W
	typedef logic [`MT_LANE_W-1:0] mt_lane_t;

endpackage

// File: mem_pattern_writer.sv
/* AXI write master, one burst in flight, no ids, strobes or error responses
   rows above 2**MT_ROW_W wrap, so burst counts beyond 64 overwrite row 0 onward
   i_start is taken only while idle */
`include "mem_test_params.svh"

module mem_pattern_writer
	import mem_test_pkg::*;
(
	input  logic                  iCLK,
	input  logic                  iRST,
	input  logic                  i_start,
	input  logic [7:0]            i_burst_count,
	input  mt_lane_t              i_seed,
	input  logic                  i_awready,
	input  logic                  i_wready,
	input  logic                  i_bvalid,
	output logic                  o_awvalid,
	output logic [`MT_ADDR_W-1:0] o_awaddr,
	output logic                  o_wvalid,
	output logic [`MT_BUS_W-1:0]  o_wdata,
	output logic                  o_wlast,
	output logic                  o_bready,
	output logic                  o_wr_done
);

	// -----------------------------------------------------------------------
	// state encoding
	// -----------------------------------------------------------------------
	localparam logic [2:0] lp_idle   = 3'd0;
	localparam logic [2:0] lp_addr   = 3'd1;
	localparam logic [2:0] lp_data   = 3'd2;
	localparam logic [2:0] lp_resp   = 3'd3;
	localparam logic [2:0] lp_finish = 3'd4;
	localparam logic [`MT_COL_W-1:0] lp_last_beat = `MT_COL_W'(`MT_BURST_LEN - 1);

	logic [2:0]          r_state;
	logic                r_awvalid;
	logic                r_wvalid;
	logic                r_wlast;
	logic                r_bready;
	logic                r_wr_done;
	// burst address, only the row field moves
	mt_addr_u            r_addr;
	// first pattern word of the current beat
	mt_lane_t            r_word;
	logic [`MT_COL_W-1:0] r_beat;
	logic [7:0]          r_burst;
	logic                q_go;
	logic                q_w_fire;
	logic                q_b_fire;
	logic                q_last_burst;

	assign q_go         = (r_state == lp_idle) & i_start;
	assign q_w_fire     = r_wvalid & i_wready;
	assign q_b_fire     = r_bready & i_bvalid;
	assign q_last_burst = (8'(r_burst + 8'd1) == i_burst_count);

	// -----------------------------------------------------------------------
	// channel control
	// -----------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			r_state   <= lp_idle;
			r_awvalid <= 1'b0;
			r_wvalid  <= 1'b0;
			r_wlast   <= 1'b0;
			r_bready  <= 1'b0;
			r_wr_done <= 1'b0;
		end
		else
		begin
			// done strobe lasts one cycle
			r_wr_done <= 1'b0;
			case (r_state)
				lp_idle:
				begin
					if (i_start)
					begin
						if (i_burst_count == 8'd0)
						begin
							r_state <= lp_finish;
						end
						else
						begin
							r_awvalid <= 1'b1;
							r_state   <= lp_addr;
						end
					end
				end
				lp_addr:
				begin
					// data valid only after the address is taken
					if (r_awvalid & i_awready)
					begin
						r_awvalid <= 1'b0;
						r_wvalid  <= 1'b1;
						r_wlast   <= (lp_last_beat == '0);
						r_state   <= lp_data;
					end
				end
				lp_data:
				begin
					if (q_w_fire)
					begin
						if (r_wlast)
						begin
							r_wvalid <= 1'b0;
							r_wlast  <= 1'b0;
							r_bready <= 1'b1;
							r_state  <= lp_resp;
						end
						else
						begin
							r_wlast <= (`MT_COL_W'(r_beat + 1'b1) == lp_last_beat);
						end
					end
				end
				lp_resp:
				begin
					if (q_b_fire)
					begin
						r_bready <= 1'b0;
						if (q_last_burst)
						begin
							r_state <= lp_finish;
						end
						else
						begin
							r_awvalid <= 1'b1;
							r_state   <= lp_addr;
						end
					end
				end
				lp_finish:
				begin
					r_wr_done <= 1'b1;
					r_state   <= lp_idle;
				end
				default:
				begin
					r_state <= lp_idle;
				end
			endcase
		end
	end

	// -----------------------------------------------------------------------
	// address and pattern counters
	// -----------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (q_go)
		begin
			r_word  <= i_seed;
			r_addr  <= '0;
			r_beat  <= '0;
			r_burst <= 8'd0;
		end
		else
		begin
			if (q_w_fire)
			begin
				r_word <= r_word + mt_lane_t'(`MT_LANES);
				r_beat <= r_beat + 1'b1;
			end
			// next row once the response is back
			if (q_b_fire)
			begin
				r_addr.f.row <= r_addr.f.row + 1'b1;
				r_burst      <= r_burst + 8'd1;
				r_beat       <= '0;
			end
		end
	end

	// lane l carries word r_word + l
	always_comb
	begin
		for (int l = 0; l < `MT_LANES; l++)
		begin
			o_wdata[l*`MT_LANE_W +: `MT_LANE_W] = r_word + mt_lane_t'(l);
		end
	end

	assign o_awvalid = r_awvalid;
	assign o_awaddr  = r_addr.word;
	assign o_wvalid  = r_wvalid;
	assign o_wlast   = r_wlast;
	assign o_bready  = r_bready;
	assign o_wr_done = r_wr_done;

endmodule

// File: mem_burst_ram.sv
/* AXI slave memory model, one burst at a time, writes win over reads
   bank, cs and byte offset of the address are ignored
   readies stay low for one cycle after reset */
`include "mem_test_params.svh"

module mem_burst_ram
	import mem_test_pkg::*;
(
	input  logic                  iCLK,
	input  logic                  iRST,
	input  logic                  i_fault_en,
	input  logic [`MT_ROW_W-1:0]  i_fault_row,
	input  logic                  i_awvalid,
	input  logic [`MT_ADDR_W-1:0] i_awaddr,
	input  logic                  i_wvalid,
	input  logic [`MT_BUS_W-1:0]  i_wdata,
	input  logic                  i_wlast,
	input  logic                  i_bready,
	input  logic                  i_arvalid,
	input  logic [`MT_ADDR_W-1:0] i_araddr,
	input  logic                  i_rready,
	output logic                  o_awready,
	output logic                  o_wready,
	output logic                  o_bvalid,
	output logic                  o_arready,
	output logic                  o_rvalid,
	output logic [`MT_BUS_W-1:0]  o_rdata,
	output logic                  o_rlast
);

	localparam logic [2:0] lp_init  = 3'd0;
	localparam logic [2:0] lp_idle  = 3'd1;
	localparam logic [2:0] lp_write = 3'd2;
	localparam logic [2:0] lp_wresp = 3'd3;
	localparam logic [2:0] lp_read  = 3'd4;
	localparam int lp_idx_w = `MT_ROW_W + `MT_COL_W;
	localparam logic [`MT_COL_W-1:0] lp_last_beat = `MT_COL_W'(`MT_BURST_LEN - 1);
	// bit 0 of every lane
	localparam logic [`MT_BUS_W-1:0] lp_fault_mask =
		{`MT_LANES{{(`MT_LANE_W-1){1'b0}}, 1'b1}};

	logic [`MT_BUS_W-1:0] mem [`MT_RAM_DEPTH];
	logic [2:0]           r_state;
	logic                 r_stalled;
	logic                 r_bvalid;
	logic                 r_rvalid;
	logic                 r_rlast;
	logic [`MT_BUS_W-1:0] r_rdata;
	// current burst position
	logic [`MT_ROW_W-1:0] r_row;
	logic [`MT_COL_W-1:0] r_col;
	mt_addr_u             q_aw;
	mt_addr_u             q_ar;
	logic                 q_aw_fire;
	logic                 q_ar_fire;
	logic                 q_w_fire;
	logic                 q_r_fire;
	logic                 q_hit;
	logic [lp_idx_w-1:0]  q_rd_idx;

	// decode both request addresses through the field view
	assign q_aw = i_awaddr;
	assign q_ar = i_araddr;

	// -----------------------------------------------------------------------
	// handshakes
	// -----------------------------------------------------------------------
	assign o_awready = (r_state == lp_idle);
	// a pending write blocks the read
	assign o_arready = (r_state == lp_idle) & ~i_awvalid;
	// faulty row costs one stall cycle per beat
	assign o_wready  = (r_state == lp_write) & (~q_hit | r_stalled);

	assign q_aw_fire = i_awvalid & o_awready;
	assign q_ar_fire = i_arvalid & o_arready;
	assign q_w_fire  = i_wvalid & o_wready;
	assign q_r_fire  = r_rvalid & i_rready;
	assign q_hit     = i_fault_en & (r_row == i_fault_row);

	// first beat comes from the request, later beats from the next col
	assign q_rd_idx = q_ar_fire ? {q_ar.f.row, q_ar.f.col}
	                            : {r_row, `MT_COL_W'(r_col + 1'b1)};

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			r_state   <= lp_init;
			r_stalled <= 1'b0;
			r_bvalid  <= 1'b0;
			r_rvalid  <= 1'b0;
			r_rlast   <= 1'b0;
		end
		else
		begin
			case (r_state)
				lp_init:
				begin
					r_state <= lp_idle;
				end
				lp_idle:
				begin
					if (q_aw_fire)
					begin
						r_stalled <= 1'b0;
						r_state   <= lp_write;
					end
					else if (q_ar_fire)
					begin
						r_rvalid <= 1'b1;
						r_rlast  <= (q_ar.f.col == lp_last_beat);
						r_state  <= lp_read;
					end
				end
				lp_write:
				begin
					if (q_w_fire)
					begin
						r_stalled <= 1'b0;
						// response one cycle after the last beat
						if (i_wlast)
						begin
							r_bvalid <= 1'b1;
							r_state  <= lp_wresp;
						end
					end
					else if (q_hit)
					begin
						r_stalled <= 1'b1;
					end
				end
				lp_wresp:
				begin
					if (r_bvalid & i_bready)
					begin
						r_bvalid <= 1'b0;
						r_state  <= lp_idle;
					end
				end
				lp_read:
				begin
					// beat holds until taken
					if (q_r_fire)
					begin
						if (r_rlast)
						begin
							r_rvalid <= 1'b0;
							r_rlast  <= 1'b0;
							r_state  <= lp_idle;
						end
						else
						begin
							r_rlast <= (`MT_COL_W'(r_col + 1'b1) == lp_last_beat);
						end
					end
				end
				default:
				begin
					r_state <= lp_idle;
				end
			endcase
		end
	end

	// -----------------------------------------------------------------------
	// storage
	// -----------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (q_aw_fire)
		begin
			r_row <= q_aw.f.row;
			r_col <= q_aw.f.col;
		end
		else if (q_ar_fire)
		begin
			r_row <= q_ar.f.row;
			r_col <= q_ar.f.col;
		end
		else if (q_w_fire | q_r_fire)
		begin
			r_col <= r_col + 1'b1;
		end

		// fault flips bit 0 of each lane on its way in
		if (q_w_fire)
		begin
			mem[{r_row, r_col}] <= q_hit ? (i_wdata ^ lp_fault_mask) : i_wdata;
		end
		if (q_ar_fire | q_r_fire)
		begin
			r_rdata <= mem[q_rd_idx];
		end
	end

	assign o_bvalid = r_bvalid;
	assign o_rvalid = r_rvalid;
	assign o_rdata  = r_rdata;
	assign o_rlast  = r_rlast;

endmodule

// File: mem_readback_checker.sv
/* AXI read master and verdict, one burst in flight
   error count saturates at 16'hFFFF, fail address keeps the first failing beat
   a start in any state clears the status and waits for the write side */
`include "mem_test_params.svh"

module mem_readback_checker
	import mem_test_pkg::*;
(
	input  logic                  iCLK,
	input  logic                  iRST,
	input  logic                  i_start,
	input  logic                  i_wr_done,
	input  logic [7:0]            i_burst_count,
	input  mt_lane_t              i_seed,
	input  logic                  i_arready,
	input  logic                  i_rvalid,
	input  logic [`MT_BUS_W-1:0]  i_rdata,
	input  logic                  i_rlast,
	output logic                  o_arvalid,
	output logic [`MT_ADDR_W-1:0] o_araddr,
	output logic                  o_rready,
	output logic                  o_test_run,
	output logic                  o_test_done,
	output logic                  o_test_fail,
	output logic [15:0]           o_err_count,
	output logic [`MT_ADDR_W-1:0] o_fail_addr
);

	localparam logic [1:0] lp_idle = 2'd0;
	localparam logic [1:0] lp_wait = 2'd1;
	localparam logic [1:0] lp_addr = 2'd2;
	localparam logic [1:0] lp_data = 2'd3;
	// wide enough for all lanes failing at once
	localparam int lp_cnt_w = $clog2(`MT_LANES + 1);

	logic [1:0]            r_state;
	logic                  r_arvalid;
	logic                  r_rready;
	logic                  r_run;
	logic                  r_done;
	logic                  r_fail;
	logic [15:0]           r_err;
	mt_addr_u              r_addr;
	mt_lane_t              r_word;
	logic [`MT_COL_W-1:0]  r_beat;
	logic [7:0]            r_burst;
	logic [`MT_ADDR_W-1:0] r_fail_addr;
	logic                  q_r_fire;
	logic                  q_last_burst;
	logic [lp_cnt_w-1:0]   q_err_lanes;
	logic [16:0]           q_err_sum;
	logic [15:0]           q_err_next;
	mt_addr_u              q_fail_addr;

	assign q_r_fire     = i_rvalid & r_rready;
	assign q_last_burst = (8'(r_burst + 8'd1) == i_burst_count);

	// -----------------------------------------------------------------------
	// compare one beat
	// -----------------------------------------------------------------------
	// expected lane l is r_word + l
	always_comb
	begin
		q_err_lanes = '0;
		for (int l = 0; l < `MT_LANES; l++)
		begin
			if (i_rdata[l*`MT_LANE_W +: `MT_LANE_W] != r_word + mt_lane_t'(l))
			begin
				q_err_lanes = q_err_lanes + 1'b1;
			end
		end
	end

	// saturate instead of wrapping
	assign q_err_sum  = {1'b0, r_err} + 17'(q_err_lanes);
	assign q_err_next = q_err_sum[16] ? 16'hFFFF : q_err_sum[15:0];

	// row of this burst with the col of this beat
	always_comb
	begin
		q_fail_addr       = r_addr;
		q_fail_addr.f.col = r_beat;
	end

	// -----------------------------------------------------------------------
	// read control and status
	// -----------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			r_state   <= lp_idle;
			r_arvalid <= 1'b0;
			r_rready  <= 1'b0;
			r_run     <= 1'b0;
			r_done    <= 1'b0;
			r_fail    <= 1'b0;
			r_err     <= 16'd0;
		end
		else if (i_start)
		begin
			r_state   <= lp_wait;
			r_arvalid <= 1'b0;
			r_rready  <= 1'b0;
			r_run     <= 1'b1;
			r_done    <= 1'b0;
			r_fail    <= 1'b0;
			r_err     <= 16'd0;
		end
		else
		begin
			case (r_state)
				lp_wait:
				begin
					// nothing to read for an empty run
					if (i_wr_done)
					begin
						if (i_burst_count == 8'd0)
						begin
							r_done  <= 1'b1;
							r_run   <= 1'b0;
							r_state <= lp_idle;
						end
						else
						begin
							r_arvalid <= 1'b1;
							r_state   <= lp_addr;
						end
					end
				end
				lp_addr:
				begin
					if (r_arvalid & i_arready)
					begin
						r_arvalid <= 1'b0;
						r_rready  <= 1'b1;
						r_state   <= lp_data;
					end
				end
				lp_data:
				begin
					if (q_r_fire)
					begin
						if (q_err_lanes != '0)
						begin
							r_err  <= q_err_next;
							r_fail <= 1'b1;
						end
						if (i_rlast)
						begin
							r_rready <= 1'b0;
							// done and run swap in the same cycle
							if (q_last_burst)
							begin
								r_done  <= 1'b1;
								r_run   <= 1'b0;
								r_state <= lp_idle;
							end
							else
							begin
								r_arvalid <= 1'b1;
								r_state   <= lp_addr;
							end
						end
					end
				end
				default:
				begin
					r_state <= lp_idle;
				end
			endcase
		end
	end

	// -----------------------------------------------------------------------
	// expected pattern and addresses
	// -----------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (i_start)
		begin
			r_word      <= i_seed;
			r_addr      <= '0;
			r_beat      <= '0;
			r_burst     <= 8'd0;
			r_fail_addr <= '0;
		end
		else if (q_r_fire)
		begin
			r_word <= r_word + mt_lane_t'(`MT_LANES);
			r_beat <= r_beat + 1'b1;
			// only the first failing beat is kept
			if ((q_err_lanes != '0) && !r_fail)
			begin
				r_fail_addr <= q_fail_addr.word;
			end
			if (i_rlast)
			begin
				r_addr.f.row <= r_addr.f.row + 1'b1;
				r_burst      <= r_burst + 8'd1;
				r_beat       <= '0;
			end
		end
	end

	assign o_arvalid   = r_arvalid;
	assign o_araddr    = r_addr.word;
	assign o_rready    = r_rready;
	assign o_test_run  = r_run;
	assign o_test_done = r_done;
	assign o_test_fail = r_fail;
	assign o_err_count = r_err;
	assign o_fail_addr = r_fail_addr;

endmodule

// File: mem_test_top.sv
/* memory test subsystem: pattern writer, burst RAM model, readback checker
   a test starts on a rising edge of i_cfg_done and ends when o_test_done rises
   status holds until the next start */
`include "mem_test_params.svh"

module mem_test_top
	import mem_test_pkg::*;
(
	input  logic                  iCLK,
	input  logic                  iRST,
	input  logic                  i_cfg_done,
	input  logic [7:0]            i_burst_count,
	input  mt_lane_t              i_seed,
	input  logic                  i_fault_en,
	input  logic [`MT_ROW_W-1:0]  i_fault_row,
	output logic                  o_test_run,
	output logic                  o_test_done,
	output logic                  o_test_fail,
	output logic [15:0]           o_err_count,
	output logic [`MT_ADDR_W-1:0] o_fail_addr
);

	logic                  r_cfg_d;
	logic                  q_start;
	// write channels
	logic                  awvalid;
	logic                  awready;
	logic [`MT_ADDR_W-1:0] awaddr;
	logic                  wvalid;
	logic                  wready;
	logic [`MT_BUS_W-1:0]  wdata;
	logic                  wlast;
	logic                  bvalid;
	logic                  bready;
	// read channels
	logic                  arvalid;
	logic                  arready;
	logic [`MT_ADDR_W-1:0] araddr;
	logic                  rvalid;
	logic                  rready;
	logic [`MT_BUS_W-1:0]  rdata;
	logic                  rlast;
	// write side finished
	logic                  wr_done;

	// ---------------------------------------------------------------------------
	// start on the rising edge of cfg done
	// ---------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			r_cfg_d <= 1'b0;
		end
		else
		begin
			r_cfg_d <= i_cfg_done;
		end
	end

	assign q_start = i_cfg_done & ~r_cfg_d;

	mem_pattern_writer mem_pattern_writer_inst (
		.iCLK          (iCLK),
		.iRST          (iRST),
		.i_start       (q_start),
		.i_burst_count (i_burst_count),
		.i_seed        (i_seed),
		.i_awready     (awready),
		.i_wready      (wready),
		.i_bvalid      (bvalid),
		.o_awvalid     (awvalid),
		.o_awaddr      (awaddr),
		.o_wvalid      (wvalid),
		.o_wdata       (wdata),
		.o_wlast       (wlast),
		.o_bready      (bready),
		.o_wr_done     (wr_done)
	);

	mem_burst_ram mem_burst_ram_inst (
		.iCLK        (iCLK),
		.iRST        (iRST),
		.i_fault_en  (i_fault_en),
		.i_fault_row (i_fault_row),
		.i_awvalid   (awvalid),
		.i_awaddr    (awaddr),
		.i_wvalid    (wvalid),
		.i_wdata     (wdata),
		.i_wlast     (wlast),
		.i_bready    (bready),
		.i_arvalid   (arvalid),
		.i_araddr    (araddr),
		.i_rready    (rready),
		.o_awready   (awready),
		.o_wready    (wready),
		.o_bvalid    (bvalid),
		.o_arready   (arready),
		.o_rvalid    (rvalid),
		.o_rdata     (rdata),
		.o_rlast     (rlast)
	);

	// reads begin on the writer's done strobe
	mem_readback_checker mem_readback_checker_inst (
		.iCLK          (iCLK),
		.iRST          (iRST),
		.i_start       (q_start),
		.i_wr_done     (wr_done),
		.i_burst_count (i_burst_count),
		.i_seed        (i_seed),
		.i_arready     (arready),
		.i_rvalid      (rvalid),
		.i_rdata       (rdata),
		.i_rlast       (rlast),
		.o_arvalid     (arvalid),
		.o_araddr      (araddr),
		.o_rready      (rready),
		.o_test_run    (o_test_run),
		.o_test_done   (o_test_done),
		.o_test_fail   (o_test_fail),
		.o_err_count   (o_err_count),
		.o_fail_addr   (o_fail_addr)
	);

endmodule

// File: tb_mem_checker.sv
/* monitor for mem_test_top status, samples on the falling clock edge
   compares on every rising edge of done and counts the verdicts */
`include "mem_test_params.svh"

module tb_mem_checker (
	input  logic                  iCLK,
	input  logic                  iRST,
	input  logic                  i_test_run,
	input  logic                  i_test_done,
	input  logic                  i_test_fail,
	input  logic [15:0]           i_err_count,
	input  logic [`MT_ADDR_W-1:0] i_fail_addr,
	input  logic [8*16-1:0]       i_name,
	input  logic                  i_exp_fail,
	input  logic [15:0]           i_exp_err,
	input  logic [`MT_ADDR_W-1:0] i_exp_addr,
	output int                    o_checked,
	output int                    o_passed,
	output int                    o_failed,
	output int                    o_proto_err
);

	logic r_done_d;
	// run seen since the last done
	logic r_seen_run;

	task automatic compare_status();
		int bad;
		bad = 0;
		if (i_test_fail !== i_exp_fail)
		begin
			$display("CHECK FAILED %0s fail expected %0b actual %0b",
				i_name, i_exp_fail, i_test_fail);
			bad++;
		end
		if (i_err_count !== i_exp_err)
		begin
			$display("CHECK FAILED %0s err_count expected %0d actual %0d",
				i_name, i_exp_err, i_err_count);
			bad++;
		end
		if (i_fail_addr !== i_exp_addr)
		begin
			$display("CHECK FAILED %0s fail_addr expected 0x%h actual 0x%h",
				i_name, i_exp_addr, i_fail_addr);
			bad++;
		end
		o_checked++;
		if (bad == 0)
		begin
			o_passed++;
			$display("test %0s passed, err_count %0d", i_name, i_err_count);
		end
		else
		begin
			o_failed++;
			$display("test %0s failed with %0d mismatches", i_name, bad);
		end
	endtask

	// ------------------------------------------------------------------------
	// status watch
	// ------------------------------------------------------------------------
	always @(negedge iCLK)
	begin
		if (iRST)
		begin
			r_done_d    = 1'b0;
			r_seen_run  = 1'b0;
			o_checked   = 0;
			o_passed    = 0;
			o_failed    = 0;
			o_proto_err = 0;
		end
		else
		begin
			// run and done never overlap
			if (i_test_run && i_test_done)
			begin
				$display("run and done are both high at time %0t", $time);
				o_proto_err++;
			end
			if (i_test_run)
			begin
				r_seen_run = 1'b1;
			end
			if (i_test_done && !r_done_d)
			begin
				if (!r_seen_run)
				begin
					$display("done rose without a preceding run at time %0t", $time);
					o_proto_err++;
				end
				compare_status();
				r_seen_run = 1'b0;
			end
			r_done_d = i_test_done;
		end
	end

endmodule

// File: tb_mem_test.sv
/* testbench for mem_test_top, a table of runs applied in a loop
   expected verdicts come from the pattern and fault rules, checked by tb_mem_checker */
`include "mem_test_params.svh"

module tb_mem_test
	import mem_test_pkg::*;
();

	localparam int lp_tests = 7;
	localparam int lp_name_w = 8 * 16;

	logic                  iCLK;
	logic                  iRST;
	logic                  i_cfg_done;
	logic [7:0]            i_burst_count;
	mt_lane_t              i_seed;
	logic                  i_fault_en;
	logic [`MT_ROW_W-1:0]  i_fault_row;
	logic                  o_test_run;
	logic                  o_test_done;
	logic                  o_test_fail;
	logic [15:0]           o_err_count;
	logic [`MT_ADDR_W-1:0] o_fail_addr;
	// current test, handed to the monitor
	logic [lp_name_w-1:0]  cur_name;
	logic                  exp_fail;
	logic [15:0]           exp_err;
	logic [`MT_ADDR_W-1:0] exp_addr;
	int                    checked;
	int                    passed;
	int                    failed;
	int                    proto_err;
	logic                  table_ready;

	// ------------------------------------------------------------------------
	// stimulus table
	// ------------------------------------------------------------------------
	logic [lp_name_w-1:0]  t_name [lp_tests];
	logic [7:0]            t_bursts [lp_tests];
	mt_lane_t              t_seed [lp_tests];
	logic                  t_fault_en [lp_tests];
	logic [`MT_ROW_W-1:0]  t_fault_row [lp_tests];
	logic                  t_exp_fail [lp_tests];
	logic [15:0]           t_exp_err [lp_tests];
	logic [`MT_ADDR_W-1:0] t_exp_addr [lp_tests];

	mem_test_top mem_test_top_inst (
		.iCLK          (iCLK),
		.iRST          (iRST),
		.i_cfg_done    (i_cfg_done),
		.i_burst_count (i_burst_count),
		.i_seed        (i_seed),
		.i_fault_en    (i_fault_en),
		.i_fault_row   (i_fault_row),
		.o_test_run    (o_test_run),
		.o_test_done   (o_test_done),
		.o_test_fail   (o_test_fail),
		.o_err_count   (o_err_count),
		.o_fail_addr   (o_fail_addr)
	);

	tb_mem_checker tb_mem_checker_inst (
		.iCLK        (iCLK),
		.iRST        (iRST),
		.i_test_run  (o_test_run),
		.i_test_done (o_test_done),
		.i_test_fail (o_test_fail),
		.i_err_count (o_err_count),
		.i_fail_addr (o_fail_addr),
		.i_name      (cur_name),
		.i_exp_fail  (exp_fail),
		.i_exp_err   (exp_err),
		.i_exp_addr  (exp_addr),
		.o_checked   (checked),
		.o_passed    (passed),
		.o_failed    (failed),
		.o_proto_err (proto_err)
	);

	// failing beat address: given row, col 0, every other field zero
	function automatic logic [`MT_ADDR_W-1:0] row_addr(input logic [`MT_ROW_W-1:0] row);
		row_addr = `MT_ADDR_W'(row) << (`MT_BANK_W + `MT_COL_W + `MT_DP_W);
	endfunction

	// expected verdict follows from which rows get written
	task automatic add_row(input int idx, input logic [lp_name_w-1:0] name,
		input logic [7:0] bursts, input mt_lane_t seed, input logic fen,
		input logic [`MT_ROW_W-1:0] frow);
		logic hit;
		hit = fen && (int'(frow) < int'(bursts));
		t_name[idx]      = name;
		t_bursts[idx]    = bursts;
		t_seed[idx]      = seed;
		t_fault_en[idx]  = fen;
		t_fault_row[idx] = frow;
		t_exp_fail[idx]  = hit;
		// every lane of every beat of the hit row is flipped
		t_exp_err[idx]   = hit ? 16'(`MT_BURST_LEN * `MT_LANES) : 16'd0;
		t_exp_addr[idx]  = hit ? row_addr(frow) : '0;
	endtask

	task automatic run_test(input int idx);
		@(posedge iCLK);
		#2;
		i_burst_count = t_bursts[idx];
		i_seed        = t_seed[idx];
		i_fault_en    = t_fault_en[idx];
		i_fault_row   = t_fault_row[idx];
		cur_name      = t_name[idx];
		exp_fail      = t_exp_fail[idx];
		exp_err       = t_exp_err[idx];
		exp_addr      = t_exp_addr[idx];
		@(posedge iCLK);
		#2;
		i_cfg_done = 1'b1;
		@(posedge iCLK);
		#2;
		i_cfg_done = 1'b0;
		// monitor bumps its count once done rises
		wait (checked == idx + 1);
	endtask

	initial
	begin
		iCLK = 1'b0;
		forever #10 iCLK = ~iCLK;
	end

	// ------------------------------------------------------------------------
	// watchdog, 40 cycles per burst plus slack per test
	// ------------------------------------------------------------------------
	initial
	begin : watchdog
		int budget;
		wait (table_ready === 1'b1);
		budget = 20;
		for (int i = 0; i < lp_tests; i++)
		begin
			budget = budget + 40 * int'(t_bursts[i]) + 100;
		end
		repeat (budget) @(posedge iCLK);
		$display("test timed out after %0d cycles", budget);
		$display("TB FAILED");
		$finish;
	end

	initial
	begin : stimulus
		mt_lane_t wrap_seed;
		void'($urandom(32'h1c80f1c3));
		iRST          = 1'b1;
		i_cfg_done    = 1'b0;
		i_burst_count = 8'd0;
		i_seed        = '0;
		i_fault_en    = 1'b0;
		i_fault_row   = '0;
		cur_name      = '0;
		exp_fail      = 1'b0;
		exp_err       = 16'd0;
		exp_addr      = '0;
		table_ready   = 1'b0;
		// 128 words from here always cross 16'hFFFF
		wrap_seed = 16'hFF90 + 16'($urandom % 32'd112);
		add_row(0, "clean_8", 8'd8, 16'h0000, 1'b0, 6'd0);
		add_row(1, "wrap_8", 8'd8, wrap_seed, 1'b0, 6'd0);
		add_row(2, "fault_row3", 8'd8, 16'h1234, 1'b1, 6'd3);
		// follows a failing run, so fail must be cleared
		add_row(3, "zero_bursts", 8'd0, 16'h0042, 1'b0, 6'd0);
		add_row(4, "fault_beyond", 8'd4, 16'hA5A5, 1'b1, 6'd5);
		add_row(5, "fault_last", 8'd8, 16'h7FFE, 1'b1, 6'd7);
		add_row(6, "clean_after", 8'd2, 16'h0100, 1'b0, 6'd0);
		table_ready = 1'b1;
		repeat (10) @(posedge iCLK);
		#2;
		iRST = 1'b0;
		for (int i = 0; i < lp_tests; i++)
		begin
			run_test(i);
		end
		@(negedge iCLK);
		$display("tests %0d, passed %0d, failed %0d, protocol errors %0d",
			checked, passed, failed, proto_err);
		if ((failed == 0) && (proto_err == 0) && (checked == lp_tests))
		begin
			$display("TB PASSED");
		end
		else
		begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: mem_test_top.f
+incdir+.
mem_test_pkg.sv
mem_pattern_writer.sv
mem_burst_ram.sv
mem_readback_checker.sv
mem_test_top.sv
tb_mem_checker.sv
tb_mem_test.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the memory test bench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module tb_mem_test \
	-Mdir obj_dir \
	-f mem_test_top.f

output="$(./obj_dir/Vtb_mem_test)"
echo "$output"

if echo "$output" | grep -qx "TB PASSED"; then
	exit 0
else
	echo "simulation reported failure"
	exit 1
fi
